// ==== sources.f ====
rtl/lq_pkg.sv
rtl/lq_ctrl.sv
rtl/lq_data_store.sv
rtl/lq_violation_check.sv
rtl/load_queue.sv
sim/load_queue_assert.sv
sim/load_queue_tb.sv

// ==== sim/load_queue_tb.sv ====
`timescale 1ns/1ps

module load_queue_tb;
    import lq_pkg::*;

    localparam int COMMIT_WIDTH = 2;
    // Rough cycle budgets per test, with a wide margin on top
    localparam int CYCLE_LIMIT = 4 * (60 + 80 + 8 * 40 + 200 + 10 * 60);

    logic clk, rst, dis_en, ld_en, refill_en, wb_ready, st_en;
    dis_info_t dis_info;
    ld_result_t ld_res;
    logic [LQ_IDX_W-1:0] refill_idx;
    logic [XLEN-1:0] refill_data;
    logic [1:0] commit_num;
    st_check_t st_chk;
    lq_idx_t alloc_idx;
    logic full, wb_en, vio_en;
    wb_data_t wb;
    vio_t vio;

    // Reference model
    logic [4:0] m_head, m_tail;
    int m_count, errors, failed, cycles, mark, rob_cnt;
    dis_info_t m_dest [LQ_DEPTH];
    logic [LQ_DEPTH-1:0] m_valid, m_av;
    logic [31:0] m_addr [LQ_DEPTH];
    logic [7:0] m_mask [LQ_DEPTH], m_fwd [LQ_DEPTH];
    logic [63:0] m_data [LQ_DEPTH];
    logic [1:0] m_size [LQ_DEPTH];
    logic m_uext [LQ_DEPTH];

    load_queue #(.COMMIT_WIDTH(COMMIT_WIDTH)) load_queue_i (
        .clk(clk), .rst(rst), .dis_en(dis_en), .dis_info(dis_info), .ld_en(ld_en),
        .ld_res(ld_res), .refill_en(refill_en), .refill_idx(refill_idx),
        .refill_data(refill_data), .wb_ready(wb_ready), .commit_num(commit_num),
        .st_en(st_en), .st_chk(st_chk), .alloc_idx(alloc_idx), .full(full),
        .wb_en(wb_en), .wb(wb), .vio_en(vio_en), .vio(vio)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Verification failed");
            $finish;
        end
    end

    function automatic logic [63:0] merge_align(logic [63:0] old, logic [7:0] fwd,
            logic [63:0] fill, logic [2:0] off, logic [1:0] size, logic uext);
        logic [63:0] m;
        logic [63:0] r;
        int nb;
        for (int b = 0; b < 8; b++) begin
            m[b*8 +: 8] = fwd[b] ? old[b*8 +: 8] : fill[b*8 +: 8];
        end
        m = m >> (off * 8);
        nb = 1 << size;
        r = '0;
        for (int b = 0; b < 8; b++) begin
            if (b < nb) begin
                r[b*8 +: 8] = m[b*8 +: 8];
            end else if (!uext && m[nb*8-1]) begin
                r[b*8 +: 8] = 8'hff;
            end
        end
        return r;
    endfunction

    task automatic mismatch(input string name, input logic [63:0] got, input logic [63:0] exp);
        $display("** Error: %s got %h expected %h", name, got, exp);
        errors++;
    endtask

    task automatic complain(input string what);
        $display("Error: %s", what);
        errors++;
    endtask

    task automatic end_test(input string name);
        if (errors == mark) begin
            $display("Test %s: done, no errors", name);
        end else begin
            $display("Test %s: done, %0d errors", name, errors - mark);
            failed++;
        end
        mark = errors;
    endtask

    task automatic clear_strobes();
        dis_en <= 1'b0;
        ld_en <= 1'b0;
        refill_en <= 1'b0;
        commit_num <= '0;
        st_en <= 1'b0;
    endtask

    task automatic idle();
        @(posedge clk);
        clear_strobes();
    endtask

    task automatic dispatch_load();
        dis_info_t info;
        info.rob_idx = ROB_IDX_W'(rob_cnt);
        info.rd = PREG_W'($urandom);
        info.we = 1'($urandom);
        @(posedge clk);
        clear_strobes();
        dis_en <= 1'b1;
        dis_info <= info;
        @(negedge clk);
        if (alloc_idx !== m_tail) mismatch("alloc_idx", alloc_idx, m_tail);
        if (full !== (m_count == LQ_DEPTH)) mismatch("full", full, m_count == LQ_DEPTH);
        if (m_count < LQ_DEPTH) begin
            m_dest[m_tail[3:0]] = info;
            m_valid[m_tail[3:0]] = 1'b1;
            m_av[m_tail[3:0]] = 1'b0;
            m_tail++;
            m_count++;
            rob_cnt++;
        end
    endtask

    task automatic send_result(input logic [4:0] ptr, input logic miss, input logic [31:0] addr,
            input logic [7:0] bmask);
        ld_result_t r;
        r.lq_idx = ptr;
        r.miss = miss;
        r.paddr = addr;
        r.byte_mask = bmask;
        r.fwd_mask = 8'($urandom);
        r.size = 2'($urandom);
        r.uext = 1'($urandom);
        r.rdata = {$urandom, $urandom};
        @(posedge clk);
        clear_strobes();
        ld_en <= 1'b1;
        ld_res <= r;
        m_av[ptr[3:0]] = 1'b1;
        m_addr[ptr[3:0]] = addr;
        m_mask[ptr[3:0]] = bmask;
        m_fwd[ptr[3:0]] = r.fwd_mask;
        m_size[ptr[3:0]] = r.size;
        m_uext[ptr[3:0]] = r.uext;
        m_data[ptr[3:0]] = r.rdata;
    endtask

    task automatic send_refill(input logic [3:0] idx);
        logic [63:0] d;
        d = {$urandom, $urandom};
        @(posedge clk);
        clear_strobes();
        refill_en <= 1'b1;
        refill_idx <= idx;
        refill_data <= d;
        m_data[idx] = merge_align(m_data[idx], m_fwd[idx], d, m_addr[idx][2:0], m_size[idx],
            m_uext[idx]);
    endtask

    task automatic commit_entries(input int n);
        int k;
        while (n > 0) begin
            k = (n > COMMIT_WIDTH) ? COMMIT_WIDTH : n;
            @(posedge clk);
            clear_strobes();
            commit_num <= 2'(k);
            for (int j = 0; j < k; j++) begin
                m_valid[m_head[3:0]] = 1'b0;
                m_head++;
            end
            m_count -= k;
            n -= k;
        end
    endtask

    task automatic check_wb(input logic [3:0] idx);
        if (wb.res !== m_data[idx]) mismatch("wb.res", wb.res, m_data[idx]);
        if (wb.rob_idx !== m_dest[idx].rob_idx)
            mismatch("wb.rob_idx", wb.rob_idx, m_dest[idx].rob_idx);
        if (wb.rd !== m_dest[idx].rd) mismatch("wb.rd", wb.rd, m_dest[idx].rd);
        if (wb.we !== m_dest[idx].we) mismatch("wb.we", wb.we, m_dest[idx].we);
    endtask

    task automatic check_store(input logic [4:0] st_ptr, input logic [31:0] addr,
            input logic [7:0] bmask);
        logic [4:0] p;
        logic found;
        found = 1'b0;
        p = st_ptr;
        while (p != m_tail && !found) begin
            if (m_valid[p[3:0]] && m_av[p[3:0]] && (m_addr[p[3:0]][31:3] == addr[31:3])
                    && |(m_mask[p[3:0]] & bmask)) begin
                found = 1'b1;
            end else begin
                p++;
            end
        end
        @(posedge clk);
        clear_strobes();
        st_en <= 1'b1;
        st_chk <= '{lq_idx: st_ptr, addr: addr, byte_mask: bmask};
        for (int c = 1; c <= 4; c++) begin
            idle();
            @(negedge clk);
            if (c == 3 && found) begin
                if (!vio_en) begin
                    complain("no violation reported for an overlapping younger load");
                end else begin
                    if (vio.lq_idx !== p) mismatch("vio.lq_idx", vio.lq_idx, p);
                    if (vio.rob_idx !== m_dest[p[3:0]].rob_idx)
                        mismatch("vio.rob_idx", vio.rob_idx, m_dest[p[3:0]].rob_idx);
                end
            end else if (vio_en) begin
                complain("violation reported at the wrong cycle or with no overlap");
            end
        end
    endtask

    initial begin
        int n, k, w;
        int pend_q[$];
        wb_data_t held;
        logic held_valid;
        void'($urandom(32'h075def55));
        rst = 1'b1;
        dis_en = 1'b0;
        dis_info = '0;
        ld_en = 1'b0;
        ld_res = '0;
        refill_en = 1'b0;
        refill_idx = '0;
        refill_data = '0;
        wb_ready = 1'b0;
        commit_num = '0;
        st_en = 1'b0;
        st_chk = '0;
        m_head = '0;
        m_tail = '0;
        m_count = 0;
        m_valid = '0;
        m_av = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        for (int j = 0; j <= LQ_DEPTH; j++) dispatch_load();
        idle();
        @(negedge clk);
        if (full !== 1'b1) mismatch("full", full, 1'b1);
        if (alloc_idx !== m_tail) mismatch("alloc_idx", alloc_idx, m_tail);
        end_test("allocation");

        for (int j = 0; j < LQ_DEPTH; j++) begin
            send_result(m_head + 5'(j), 1'b0, $urandom, 8'($urandom));
            @(negedge clk);
            if (wb_en) complain("writeback raised after a hit");
        end
        commit_entries(LQ_DEPTH);
        idle();
        @(negedge clk);
        if (wb_en) complain("writeback raised after commit of hits");
        if (full !== 1'b0) mismatch("full", full, 1'b0);
        dispatch_load();
        commit_entries(1);
        end_test("hit and commit");

        wb_ready <= 1'b1;
        for (int j = 0; j < 8; j++) begin
            dispatch_load();
            send_result(m_head, 1'b1, $urandom, 8'($urandom));
            send_refill(m_head[3:0]);
            idle();
            w = 0;
            @(negedge clk);
            while (!wb_en && w < 20) begin
                @(negedge clk);
                w++;
            end
            if (!wb_en) complain("refilled load never reached writeback");
            else check_wb(m_head[3:0]);
            commit_entries(1);
        end
        end_test("miss refill");

        wb_ready <= 1'b0;
        for (int j = 0; j < 6; j++) dispatch_load();
        for (int j = 0; j < 6; j++) send_result(m_head + 5'(j), 1'b1, $urandom, 8'($urandom));
        // Refill top down so lower entries become ready behind the held one
        for (int i = LQ_DEPTH - 1; i >= 0; i--) begin
            if (m_valid[i]) begin
                send_refill(4'(i));
                if (pend_q.size() == 0) pend_q.push_back(i);
            end
        end
        // The held entry leaves first, then the rest lowest index first
        for (int i = 0; i < LQ_DEPTH; i++) begin
            if (m_valid[i] && i != pend_q[0]) pend_q.push_back(i);
        end
        held_valid = 1'b0;
        w = 0;
        while (pend_q.size() > 0 && w < 200) begin
            @(posedge clk);
            clear_strobes();
            wb_ready <= 1'($urandom);
            @(negedge clk);
            w++;
            if (!wb_en) begin
                complain("writeback enable low with refilled loads pending");
            end else begin
                check_wb(4'(pend_q[0]));
                if (held_valid && wb !== held) mismatch("wb", wb[63:0], held[63:0]);
                held = wb;
                held_valid = !wb_ready;
                if (wb_ready) void'(pend_q.pop_front());
            end
        end
        if (pend_q.size() > 0) complain("refilled loads still waiting after 200 cycles");
        idle();
        @(negedge clk);
        if (wb_en) complain("extra writeback after all loads were written");
        commit_entries(6);
        end_test("writeback order");

        for (int r = 0; r < 10; r++) begin
            n = 4 + $urandom % 9;
            for (int j = 0; j < n; j++) dispatch_load();
            for (int j = 0; j < n; j++) begin
                if ($urandom % 4 != 0) begin
                    send_result(m_head + 5'(j), 1'b0, 32'h1000 + ($urandom % 3) * 8 + $urandom % 8,
                        8'($urandom) | (8'h1 << ($urandom % 8)));
                end
            end
            k = $urandom % (n + 1);
            check_store(m_head + 5'(k), ($urandom % 4 == 0) ? 32'h8000_0000 :
                32'h1000 + ($urandom % 3) * 8, 8'($urandom) | 8'h10);
            commit_entries(n);
        end
        end_test("violation");

        $display("Tests run: 5, failed: %0d, errors: %0d", failed, errors);
        if (errors == 0 && failed == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== sim/load_queue_assert.sv ====
`timescale 1ns/1ps

module load_queue_assert (
    input logic                        clk,
    input logic                        rst,
    input logic                        wb_en,
    input logic                        wb_ready,
    input logic [lq_pkg::LQ_IDX_W-1:0] wb_idx,
    input logic                        full,
    input lq_pkg::lq_idx_t             head,
    input lq_pkg::lq_idx_t             tail,
    input logic [lq_pkg::LQ_DEPTH-1:0] valid_vec,
    input logic                        vio_en
);
    import lq_pkg::*;

    logic [LQ_IDX_W:0] used;

    // Entries in use from the pointers, a full lap reads as LQ_DEPTH
    assign used = tail - head;

    // A stalled writeback must not move to another entry
    wb_hold_a: assert property (@(posedge clk) disable iff (rst)
        wb_en && !wb_ready |=> wb_en && $stable(wb_idx))
        else $error("wb_en or wb_idx changed under back-pressure");

    full_valid_a: assert property (@(posedge clk) disable iff (rst)
        full |-> &valid_vec)
        else $error("full set while some entry is free");

    occupancy_a: assert property (@(posedge clk) disable iff (rst)
        $countones(valid_vec) == int'(used))
        else $error("valid entry count differs from the pointer distance");

    vio_pulse_a: assert property (@(posedge clk) disable iff (rst)
        vio_en |=> !vio_en)
        else $error("vio_en high on two consecutive cycles");

endmodule

bind load_queue load_queue_assert load_queue_assert_i (
    .clk       (clk),
    .rst       (rst),
    .wb_en     (lq_ctrl_i.wb_en),
    .wb_ready  (wb_ready),
    .wb_idx    (lq_ctrl_i.wb_idx),
    .full      (lq_ctrl_i.full),
    .head      (lq_ctrl_i.head),
    .tail      (lq_ctrl_i.tail),
    .valid_vec (lq_ctrl_i.valid_vec),
    .vio_en    (vio_en)
);

// ==== rtl/load_queue.sv ====
`timescale 1ns/1ps

module load_queue #(
    parameter int COMMIT_WIDTH = 2
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               dis_en,
    input  lq_pkg::dis_info_t                  dis_info,
    input  logic                               ld_en,
    input  lq_pkg::ld_result_t                 ld_res,
    input  logic                               refill_en,
    input  logic [lq_pkg::LQ_IDX_W-1:0]        refill_idx,
    input  logic [lq_pkg::XLEN-1:0]            refill_data,
    input  logic                               wb_ready,
    input  logic [$clog2(COMMIT_WIDTH+1)-1:0]  commit_num,
    input  logic                               st_en,
    input  lq_pkg::st_check_t                  st_chk,
    output lq_pkg::lq_idx_t                    alloc_idx,
    output logic                               full,
    output logic                               wb_en,
    output lq_pkg::wb_data_t                   wb,
    output logic                               vio_en,
    output lq_pkg::vio_t                       vio
);
    import lq_pkg::*;

    logic                 dis_fire;
    lq_idx_t              head;
    logic [LQ_DEPTH-1:0]  valid_vec;
    logic [LQ_DEPTH-1:0]  addr_valid_vec;
    logic [LQ_IDX_W-1:0]  wb_idx;
    logic [LQ_IDX_W-1:0]  vio_idx;
    logic [ROB_IDX_W-1:0] vio_rob_idx;

    lq_ctrl #(
        .COMMIT_WIDTH(COMMIT_WIDTH)
    ) lq_ctrl_i (
        .clk            (clk),
        .rst            (rst),
        .dis_en         (dis_en),
        .ld_en          (ld_en),
        .ld_res         (ld_res),
        .refill_en      (refill_en),
        .refill_idx     (refill_idx),
        .wb_ready       (wb_ready),
        .commit_num     (commit_num),
        .alloc_idx      (alloc_idx),
        .full           (full),
        .dis_fire       (dis_fire),
        .head           (head),
        .valid_vec      (valid_vec),
        .addr_valid_vec (addr_valid_vec),
        .wb_en          (wb_en),
        .wb_idx         (wb_idx)
    );

    lq_data_store lq_data_store_i (
        .clk         (clk),
        .rst         (rst),
        .dis_fire    (dis_fire),
        .alloc_idx   (alloc_idx),
        .dis_info    (dis_info),
        .ld_en       (ld_en),
        .ld_res      (ld_res),
        .refill_en   (refill_en),
        .refill_idx  (refill_idx),
        .refill_data (refill_data),
        .wb_idx      (wb_idx),
        .vio_idx     (vio_idx),
        .wb          (wb),
        .vio_rob_idx (vio_rob_idx)
    );

    lq_violation_check lq_violation_check_i (
        .clk            (clk),
        .rst            (rst),
        .ld_en          (ld_en),
        .ld_res         (ld_res),
        .head           (head),
        .valid_vec      (valid_vec),
        .addr_valid_vec (addr_valid_vec),
        .st_en          (st_en),
        .st_chk         (st_chk),
        .vio_rob_idx    (vio_rob_idx),
        .vio_en         (vio_en),
        .vio_idx        (vio_idx),
        .vio            (vio)
    );

endmodule

// ==== rtl/lq_violation_check.sv ====
`timescale 1ns/1ps

module lq_violation_check (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          ld_en,
    input  lq_pkg::ld_result_t            ld_res,
    input  lq_pkg::lq_idx_t               head,
    input  logic [lq_pkg::LQ_DEPTH-1:0]   valid_vec,
    input  logic [lq_pkg::LQ_DEPTH-1:0]   addr_valid_vec,
    input  logic                          st_en,
    input  lq_pkg::st_check_t             st_chk,
    input  logic [lq_pkg::ROB_IDX_W-1:0]  vio_rob_idx,
    output logic                          vio_en,
    output logic [lq_pkg::LQ_IDX_W-1:0]   vio_idx,
    output lq_pkg::vio_t                  vio
);
    import lq_pkg::*;

    localparam int WADDR_W = PADDR_W - OFFSET_W;

    logic [WADDR_W-1:0]    word_mem [LQ_DEPTH];
    logic [DATA_BYTES-1:0] mask_mem [LQ_DEPTH];

    logic [LQ_IDX_W:0]     st_dist;
    logic [LQ_IDX_W:0]     ent_dist [LQ_DEPTH];
    logic [LQ_DEPTH-1:0]   hit_vec;

    logic                  s1_valid;
    logic [LQ_DEPTH-1:0]   s1_vec;
    lq_idx_t               s1_st;
    logic [LQ_IDX_W-1:0]   sel_idx;
    lq_idx_t               sel;
    logic                  s2_valid;
    lq_idx_t               s2_sel;

    always_ff @(posedge clk) begin
        if (ld_en) begin
            word_mem[ld_res.lq_idx.idx] <= ld_res.paddr[PADDR_W-1:OFFSET_W];
            mask_mem[ld_res.lq_idx.idx] <= ld_res.byte_mask;
        end
    end

    // Age as distance from head; store distance of a full lap leaves no younger load
    assign st_dist = st_chk.lq_idx - head;

    always_comb begin
        for (int i = 0; i < LQ_DEPTH; i++) begin
            ent_dist[i] = {1'b0, LQ_IDX_W'(i) - head.idx};
            hit_vec[i] = valid_vec[i] && addr_valid_vec[i]
                && (word_mem[i] == st_chk.addr[PADDR_W-1:OFFSET_W])
                && (|(mask_mem[i] & st_chk.byte_mask))
                && (ent_dist[i] >= st_dist);
        end
    end

    // Walk forward from the store index so the nearest younger load wins
    always_comb begin
        sel_idx = s1_st.idx;
        for (int k = LQ_DEPTH - 1; k >= 0; k--) begin
            if (s1_vec[LQ_IDX_W'(s1_st.idx + k)]) begin
                sel_idx = LQ_IDX_W'(s1_st.idx + k);
            end
        end
        sel.idx = sel_idx;
        sel.dir = (sel_idx >= s1_st.idx) ? s1_st.dir : !s1_st.dir;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            vio_en <= 1'b0;
        end else begin
            s1_valid <= st_en && (|hit_vec);
            s2_valid <= s1_valid;
            vio_en <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_vec <= hit_vec;
        s1_st <= st_chk.lq_idx;
        s2_sel <= sel;
        vio.lq_idx <= s2_sel;
        vio.rob_idx <= vio_rob_idx;
    end

    assign vio_idx = s2_sel.idx;

endmodule

// ==== rtl/lq_data_store.sv ====
`timescale 1ns/1ps

module lq_data_store (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          dis_fire,
    input  lq_pkg::lq_idx_t               alloc_idx,
    input  lq_pkg::dis_info_t             dis_info,
    input  logic                          ld_en,
    input  lq_pkg::ld_result_t            ld_res,
    input  logic                          refill_en,
    input  logic [lq_pkg::LQ_IDX_W-1:0]   refill_idx,
    input  logic [lq_pkg::XLEN-1:0]       refill_data,
    input  logic [lq_pkg::LQ_IDX_W-1:0]   wb_idx,
    input  logic [lq_pkg::LQ_IDX_W-1:0]   vio_idx,
    output lq_pkg::wb_data_t              wb,
    output logic [lq_pkg::ROB_IDX_W-1:0]  vio_rob_idx
);
    import lq_pkg::*;

    dis_info_t       dest_mem [LQ_DEPTH];
    access_info_t    info_mem [LQ_DEPTH];
    logic [XLEN-1:0] data_mem [LQ_DEPTH];

    access_info_t    ref_info;
    logic [XLEN-1:0] ref_old;
    logic [XLEN-1:0] merged;
    logic [XLEN-1:0] shifted;
    logic [XLEN-1:0] aligned;
    logic            sign;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < LQ_DEPTH; i++) begin
                dest_mem[i] <= '0;
            end
        end else if (dis_fire) begin
            dest_mem[alloc_idx.idx] <= dis_info;
        end
    end

    // Refill merge: forwarded bytes win over the cache line
    always_comb begin
        ref_info = info_mem[refill_idx];
        ref_old = data_mem[refill_idx];
        for (int b = 0; b < DATA_BYTES; b++) begin
            if (ref_info.fwd_mask[b]) begin
                merged[b*8 +: 8] = ref_old[b*8 +: 8];
            end else begin
                merged[b*8 +: 8] = refill_data[b*8 +: 8];
            end
        end
    end

    assign shifted = merged >> {ref_info.offset, 3'b000};
    assign sign = !ref_info.uext;

    always_comb begin
        case (ref_info.size)
            2'd0: begin
                aligned = {{(XLEN-8){sign & shifted[7]}}, shifted[7:0]};
            end
            2'd1: begin
                aligned = {{(XLEN-16){sign & shifted[15]}}, shifted[15:0]};
            end
            2'd2: begin
                aligned = {{(XLEN-32){sign & shifted[31]}}, shifted[31:0]};
            end
            default: begin
                aligned = shifted;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (ld_en && ld_res.miss) begin
            data_mem[ld_res.lq_idx.idx] <= ld_res.rdata;
            info_mem[ld_res.lq_idx.idx].fwd_mask <= ld_res.fwd_mask;
            info_mem[ld_res.lq_idx.idx].offset <= ld_res.paddr[OFFSET_W-1:0];
            info_mem[ld_res.lq_idx.idx].size <= ld_res.size;
            info_mem[ld_res.lq_idx.idx].uext <= ld_res.uext;
        end
        // Aligned result replaces the partial word
        if (refill_en) begin
            data_mem[refill_idx] <= aligned;
        end
    end

    always_comb begin
        wb.rob_idx = dest_mem[wb_idx].rob_idx;
        wb.rd = dest_mem[wb_idx].rd;
        wb.we = dest_mem[wb_idx].we;
        wb.res = data_mem[wb_idx];
    end

    assign vio_rob_idx = dest_mem[vio_idx].rob_idx;

endmodule

// ==== rtl/lq_ctrl.sv ====
`timescale 1ns/1ps

module lq_ctrl #(
    parameter int COMMIT_WIDTH = 2
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               dis_en,
    input  logic                               ld_en,
    input  lq_pkg::ld_result_t                 ld_res,
    input  logic                               refill_en,
    input  logic [lq_pkg::LQ_IDX_W-1:0]        refill_idx,
    input  logic                               wb_ready,
    input  logic [$clog2(COMMIT_WIDTH+1)-1:0]  commit_num,
    output lq_pkg::lq_idx_t                    alloc_idx,
    output logic                               full,
    output logic                               dis_fire,
    output lq_pkg::lq_idx_t                    head,
    output logic [lq_pkg::LQ_DEPTH-1:0]        valid_vec,
    output logic [lq_pkg::LQ_DEPTH-1:0]        addr_valid_vec,
    output logic                               wb_en,
    output logic [lq_pkg::LQ_IDX_W-1:0]        wb_idx
);
    import lq_pkg::*;

    localparam int PTR_W = LQ_IDX_W + 1;

    lq_idx_t             tail;
    logic [PTR_W-1:0]    head_n;
    logic [PTR_W-1:0]    tail_n;

    logic [LQ_DEPTH-1:0] valid;
    logic [LQ_DEPTH-1:0] miss;
    logic [LQ_DEPTH-1:0] addr_valid;
    logic [LQ_DEPTH-1:0] refilled;
    logic [LQ_DEPTH-1:0] written;
    logic [LQ_DEPTH-1:0] commit_mask;

    logic [LQ_DEPTH-1:0] wb_pend;
    logic [LQ_IDX_W-1:0] pick_idx;
    logic                wb_hold;
    logic [LQ_IDX_W-1:0] hold_idx;
    logic                wb_fire;

    // Same index with opposite laps means every entry is in use
    assign full = (head.idx == tail.idx) && (head.dir != tail.dir);
    assign dis_fire = dis_en && !full;
    assign alloc_idx = tail;

    // The carry out of the index flips the direction bit on wrap
    assign tail_n = tail + PTR_W'(1);
    assign head_n = head + PTR_W'(commit_num);

    always_comb begin
        commit_mask = '0;
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            if (i < int'(commit_num)) begin
                commit_mask[LQ_IDX_W'(head.idx + i)] = 1'b1;
            end
        end
    end

    // Missed loads with refilled data still owed to the register file
    assign wb_pend = valid & miss & refilled & ~written;

    always_comb begin
        pick_idx = '0;
        for (int i = LQ_DEPTH - 1; i >= 0; i--) begin
            if (wb_pend[i]) begin
                pick_idx = LQ_IDX_W'(i);
            end
        end
    end

    // A stalled writeback keeps its entry even if a lower one becomes ready
    assign wb_en = |wb_pend;
    assign wb_idx = wb_hold ? hold_idx : pick_idx;
    assign wb_fire = wb_en && wb_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_hold <= 1'b0;
        end else begin
            wb_hold <= wb_en && !wb_ready;
        end
    end

    always_ff @(posedge clk) begin
        hold_idx <= wb_idx;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            valid <= '0;
            miss <= '0;
            addr_valid <= '0;
            refilled <= '0;
            written <= '0;
        end else begin
            head <= head_n;
            valid <= valid & ~commit_mask;
            if (ld_en) begin
                addr_valid[ld_res.lq_idx.idx] <= 1'b1;
                miss[ld_res.lq_idx.idx] <= ld_res.miss;
                refilled[ld_res.lq_idx.idx] <= 1'b0;
                // a hit was already written back by the pipeline
                written[ld_res.lq_idx.idx] <= !ld_res.miss;
            end
            if (refill_en) begin
                refilled[refill_idx] <= 1'b1;
            end
            if (wb_fire) begin
                written[wb_idx] <= 1'b1;
            end
            if (dis_fire) begin
                tail <= tail_n;
                valid[tail.idx] <= 1'b1;
                miss[tail.idx] <= 1'b0;
                addr_valid[tail.idx] <= 1'b0;
                refilled[tail.idx] <= 1'b0;
                written[tail.idx] <= 1'b0;
            end
        end
    end

    assign valid_vec = valid;
    assign addr_valid_vec = addr_valid;

endmodule

// ==== rtl/lq_pkg.sv ====
package lq_pkg;

    localparam int LQ_DEPTH = 16;
    localparam int LQ_IDX_W = 4;
    localparam int XLEN = 64;
    localparam int DATA_BYTES = 8;
    localparam int OFFSET_W = 3;
    localparam int PADDR_W = 32;
    localparam int ROB_IDX_W = 6;
    localparam int PREG_W = 7;

    // Queue index with a wrap direction bit on top
    typedef struct packed {
        logic                dir;
        logic [LQ_IDX_W-1:0] idx;
    } lq_idx_t;

    typedef struct packed {
        logic [ROB_IDX_W-1:0] rob_idx;
        logic [PREG_W-1:0]    rd;
        logic                 we;
    } dis_info_t;

    // Result of a load leaving the load pipeline
    typedef struct packed {
        lq_idx_t               lq_idx;
        logic                  miss;
        logic [PADDR_W-1:0]    paddr;
        logic [DATA_BYTES-1:0] byte_mask;
        logic [DATA_BYTES-1:0] fwd_mask;
        logic [1:0]            size;
        logic                  uext;
        logic [XLEN-1:0]       rdata;
    } ld_result_t;

    // Bytes already forwarded plus what the refill aligner needs
    typedef struct packed {
        logic [DATA_BYTES-1:0] fwd_mask;
        logic [OFFSET_W-1:0]   offset;
        logic [1:0]            size;
        logic                  uext;
    } access_info_t;

    typedef struct packed {
        logic [ROB_IDX_W-1:0] rob_idx;
        logic [PREG_W-1:0]    rd;
        logic                 we;
        logic [XLEN-1:0]      res;
    } wb_data_t;

    typedef struct packed {
        lq_idx_t               lq_idx;
        logic [PADDR_W-1:0]    addr;
        logic [DATA_BYTES-1:0] byte_mask;
    } st_check_t;

    typedef struct packed {
        lq_idx_t              lq_idx;
        logic [ROB_IDX_W-1:0] rob_idx;
    } vio_t;

endpackage
